// File: cache_bank.f
+incdir+testbench
logic/bank_pkg.sv
logic/bank_htu.sv
logic/bank_isu.sv
logic/bank_sram_ctrl.sv
logic/bank_wbuffer.sv
logic/bank_biu.sv
logic/bank_top.sv
testbench/bank_tb.sv

// File: Bender.yml
package:
  name: cache_bank

sources:
  - logic/bank_pkg.sv
  - logic/bank_htu.sv
  - logic/bank_isu.sv
  - logic/bank_sram_ctrl.sv
  - logic/bank_wbuffer.sv
  - logic/bank_biu.sv
  - logic/bank_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/bank_tb.sv

// File: testbench/bank_tb_util.svh
`ifndef BANK_TB_UTIL_SVH
`define BANK_TB_UTIL_SVH

// Galois LFSR stepped once per bit taken.
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    r = {r[30:0], lfsr_q[0]};
  end
  return r;
endfunction

function automatic logic [bank_pkg::HALF_BITS-1:0] rand_half();
  logic [bank_pkg::HALF_BITS-1:0] h;
  for (int i = 0; i < bank_pkg::HALF_BITS / 32; i++) h[32*i +: 32] = rand_bits(32);
  return h;
endfunction

function automatic logic [bank_pkg::TAG_BITS-1:0] tag_value(input logic [1:0] idx);
  case (idx)
    2'd0:    return 25'h000_0000;
    2'd1:    return 25'h012_3457;
    2'd2:    return 25'h1ab_cde0;
    default: return 25'h1ff_ffff;
  endcase
endfunction

// Index into the small line tables, or -1 for a foreign address.
function automatic int line_index(input logic [bank_pkg::LINE_ADDR_BITS-1:0] la);
  for (int t = 0; t < 4; t++) begin
    if (tag_value(2'(t)) == la[bank_pkg::LINE_ADDR_BITS-1:2]) return t * 4 + int'(la[1:0]);
  end
  return -1;
endfunction

function automatic logic [bank_pkg::LINE_BITS-1:0] init_line(
  input logic [bank_pkg::LINE_ADDR_BITS-1:0] la
);
  logic [bank_pkg::LINE_BITS-1:0] line;
  for (int w = 0; w < bank_pkg::LINE_BITS / 32; w++) line[32*w +: 32] = 32'(la) ^ 32'(w);
  return line;
endfunction

task automatic init_model();
  logic [bank_pkg::LINE_BITS-1:0] line;
  for (int i = 0; i < NUM_LINES; i++) begin
    line = init_line({tag_value(2'(i / 4)), 2'(i % 4)});
    backing[i]        = line;
    model_half[2*i]   = line[bank_pkg::HALF_BITS-1:0];
    model_half[2*i+1] = line[bank_pkg::LINE_BITS-1:bank_pkg::HALF_BITS];
    line_dirty[i]     = 1'b0;
  end
endtask

task automatic stop_with_failure(input string reason);
  $display("%s", reason);
  $display("Test FAILED");
  $fatal(1, "Simulation stopped.");
endtask

task automatic check_value(input string what, input logic [255:0] got, input logic [255:0] exp);
  if (got !== exp) begin
    stop_with_failure($sformatf("ERROR at %0t: %s is %0h, expected %0h", $time, what, got, exp));
  end
endtask

task automatic memory_read(input logic [bank_pkg::LINE_ADDR_BITS-1:0] addr);
  int idx;
  idx = line_index(addr);
  if (idx < 0) begin
    stop_with_failure($sformatf("Memory read to an unknown line address %0h.", addr));
  end else begin
    fill_data_q.push_back(backing[idx]);
    fill_due_q.push_back(cycle + 1 + int'(rand_bits(3)));  // One to eight cycles.
  end
endtask

task automatic memory_write(
  input logic [bank_pkg::LINE_ADDR_BITS-1:0] addr,
  input logic [bank_pkg::LINE_BITS-1:0]      data
);
  int idx;
  idx = line_index(addr);
  if (idx < 0) begin
    stop_with_failure($sformatf("Memory write to an unknown line address %0h.", addr));
  end else if (!line_dirty[idx]) begin
    stop_with_failure($sformatf(
      "Memory write to line %0h, which was not written since its last write back.", addr));
  end else begin
    check_value("memory write line", data, {model_half[2*idx+1], model_half[2*idx]});
    backing[idx]    = data;
    line_dirty[idx] = 1'b0;
  end
endtask

task automatic drive_memory();
  mem_rdata_valid_i = 1'b0;
  if (fill_due_q.size() > 0 && fill_due_q[0] <= cycle) begin
    mem_rdata_valid_i = 1'b1;
    mem_rdata_i       = fill_data_q.pop_front();
    fill_due_q.delete(0);
  end
  mem_rd_ready_i = 1'(rand_bits(1));
  mem_wr_ready_i = 1'(rand_bits(1));
endtask

`endif

// File: testbench/bank_tb.sv
module bank_tb;

  localparam int NUM_REQS      = 400;
  localparam int MAX_OUTSTAND  = 4;
  localparam int CLK_PERIOD    = 40;
  localparam int WATCHDOG_TIME = NUM_REQS * 80 * CLK_PERIOD;
  localparam int NUM_LINES     = 16;  // Four tags in each of four sets.

  logic                                clk_i;
  logic                                rst_i;
  logic                                req_valid_i;
  logic                                req_ready_o;
  logic [bank_pkg::CH_BITS-1:0]        req_ch_id_i;
  bank_pkg::bank_op_e                  req_op_i;
  logic [bank_pkg::ADDR_BITS-1:0]      req_addr_i;
  logic [bank_pkg::WBUF_ID_BITS-1:0]   req_wbuf_id_i;
  logic                                wbuf_fill_valid_i;
  logic [bank_pkg::WBUF_ID_BITS-1:0]   wbuf_fill_id_i;
  logic [bank_pkg::HALF_BITS-1:0]      wbuf_fill_data_i;
  logic                                resp_valid_o;
  logic                                resp_ready_i;
  logic [bank_pkg::CH_BITS-1:0]        resp_ch_id_o;
  logic [bank_pkg::HALF_BITS-1:0]      resp_data_o;
  logic                                mem_rd_valid_o;
  logic                                mem_rd_ready_i;
  logic [bank_pkg::LINE_ADDR_BITS-1:0] mem_rd_addr_o;
  logic                                mem_rdata_valid_i;
  logic [bank_pkg::LINE_BITS-1:0]      mem_rdata_i;
  logic                                mem_wr_valid_o;
  logic                                mem_wr_ready_i;
  logic [bank_pkg::LINE_ADDR_BITS-1:0] mem_wr_addr_o;
  logic [bank_pkg::LINE_BITS-1:0]      mem_wr_data_o;

  logic [31:0] lfsr_q = 32'd95;
  logic [bank_pkg::HALF_BITS-1:0] model_half [2*NUM_LINES];  // Latest value of each half.
  logic [bank_pkg::LINE_BITS-1:0] backing [NUM_LINES];
  logic line_dirty [NUM_LINES];  // Written since the last write back.
  logic [bank_pkg::CH_BITS-1:0] exp_ch_q [$];
  logic exp_wr_q [$];
  int exp_half_q [$];
  logic [bank_pkg::HALF_BITS-1:0] exp_data_q [$];
  logic [bank_pkg::LINE_BITS-1:0] fill_data_q [$];
  int fill_due_q [$];
  int cycle;
  int issued;
  int responded;
  logic have_req;
  logic need_fill;
  int req_half;
  logic [bank_pkg::HALF_BITS-1:0] req_wdata;
  logic [bank_pkg::WBUF_ID_BITS-1:0] next_wid;

  `include "bank_tb_util.svh"

  bank_top dut_i (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic new_request();
    logic [1:0] tag_idx;
    logic [bank_pkg::BANK_SET_BITS-1:0] set;
    logic off;
    tag_idx     = 2'(rand_bits(2));
    set         = 2'(rand_bits(2));
    off         = 1'(rand_bits(1));
    req_ch_id_i = 2'(rand_bits(2));
    req_op_i    = rand_bits(1) == 32'd1 ? bank_pkg::BANK_OP_WRITE : bank_pkg::BANK_OP_READ;
    req_addr_i  = {tag_value(tag_idx), set, off};
    req_half    = int'({tag_idx, set, off});
    need_fill   = (req_op_i == bank_pkg::BANK_OP_WRITE);
    if (need_fill) begin
      req_wdata     = rand_half();
      req_wbuf_id_i = next_wid;
      next_wid      = next_wid + 1'b1;  // Round robin ids.
    end
    have_req = 1'b1;
  endtask

  // Store data goes into the write buffer one cycle ahead of its request.
  task automatic drive_request();
    wbuf_fill_valid_i = 1'b0;
    req_valid_i       = 1'b0;
    if (have_req && need_fill) begin
      wbuf_fill_valid_i = 1'b1;
      wbuf_fill_id_i    = req_wbuf_id_i;
      wbuf_fill_data_i  = req_wdata;
      need_fill         = 1'b0;
    end else if (have_req) begin
      req_valid_i = 1'b1;
    end
  endtask

  task automatic check_response();
    logic [bank_pkg::CH_BITS-1:0] ch;
    logic wr;
    int h;
    logic [bank_pkg::HALF_BITS-1:0] wdata;
    if (exp_ch_q.size() == 0) begin
      stop_with_failure("A response arrived with no request outstanding.");
    end else begin
      ch    = exp_ch_q.pop_front();
      wr    = exp_wr_q.pop_front();
      h     = exp_half_q.pop_front();
      wdata = exp_data_q.pop_front();
      if (wr) begin
        model_half[h]       = wdata;
        line_dirty[h >> 1]  = 1'b1;
      end
      check_value("response channel", 256'(resp_ch_id_o), 256'(ch));
      check_value("response data", 256'(resp_data_o), 256'(model_half[h]));
      responded++;
    end
  endtask

  // Handshakes are sampled at the falling edge and inputs change after the rising edge.
  task automatic run_cycle();
    logic req_fire;
    logic resp_fire;
    logic rd_fire;
    logic wr_fire;
    @(negedge clk_i);
    req_fire  = req_valid_i && req_ready_o;
    resp_fire = resp_valid_o && resp_ready_i;
    rd_fire   = mem_rd_valid_o && mem_rd_ready_i;
    wr_fire   = mem_wr_valid_o && mem_wr_ready_i;
    if (wr_fire) memory_write(mem_wr_addr_o, mem_wr_data_o);
    if (rd_fire) memory_read(mem_rd_addr_o);
    if (resp_fire) check_response();
    if (req_fire) begin
      exp_ch_q.push_back(req_ch_id_i);
      exp_wr_q.push_back(req_op_i == bank_pkg::BANK_OP_WRITE);
      exp_half_q.push_back(req_half);
      exp_data_q.push_back(req_wdata);
      issued++;
      have_req = 1'b0;
    end
    @(posedge clk_i);
    #2;
    cycle++;
    drive_memory();
    resp_ready_i = 1'(rand_bits(1));
    if (!have_req && issued < NUM_REQS && issued - responded < MAX_OUTSTAND) new_request();
    drive_request();
  endtask

  initial begin
    clk_i             = 1'b0;
    rst_i             = 1'b1;
    req_valid_i       = 1'b0;
    req_ch_id_i       = '0;
    req_op_i          = bank_pkg::BANK_OP_READ;
    req_addr_i        = '0;
    req_wbuf_id_i     = '0;
    wbuf_fill_valid_i = 1'b0;
    wbuf_fill_id_i    = '0;
    wbuf_fill_data_i  = '0;
    resp_ready_i      = 1'b0;
    mem_rd_ready_i    = 1'b0;
    mem_rdata_valid_i = 1'b0;
    mem_rdata_i       = '0;
    mem_wr_ready_i    = 1'b0;
    cycle             = 0;
    issued            = 0;
    responded         = 0;
    have_req          = 1'b0;
    need_fill         = 1'b0;
    req_half          = 0;
    req_wdata         = '0;
    next_wid          = '0;
    init_model();
    repeat (2) @(posedge clk_i);
    #2;
    rst_i = 1'b0;
    @(negedge clk_i);
    check_value("resp_valid_o after reset", 256'(resp_valid_o), 256'(0));
    check_value("mem_rd_valid_o after reset", 256'(mem_rd_valid_o), 256'(0));
    check_value("mem_wr_valid_o after reset", 256'(mem_wr_valid_o), 256'(0));
    check_value("req_ready_o after reset", 256'(req_ready_o), 256'(1));
    while (responded < NUM_REQS) run_cycle();
    repeat (20) run_cycle();  // Catch late extra responses.
    check_value("resp_valid_o at the end", 256'(resp_valid_o), 256'(0));
    check_value("mem_rd_valid_o at the end", 256'(mem_rd_valid_o), 256'(0));
    check_value("req_ready_o at the end", 256'(req_ready_o), 256'(1));
    check_value("unreturned fill lines", 256'(fill_due_q.size()), 256'(0));
    $display("Test OK");
    $finish;
  end

  initial begin
    #(WATCHDOG_TIME);
    stop_with_failure("The run timed out before all responses arrived.");
  end

endmodule

// File: logic/bank_top.sv
module bank_top (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  input  logic [bank_pkg::CH_BITS-1:0]        req_ch_id_i,
  input  bank_pkg::bank_op_e                  req_op_i,
  input  logic [bank_pkg::ADDR_BITS-1:0]      req_addr_i,
  input  logic [bank_pkg::WBUF_ID_BITS-1:0]   req_wbuf_id_i,
  input  logic                                wbuf_fill_valid_i,
  input  logic [bank_pkg::WBUF_ID_BITS-1:0]   wbuf_fill_id_i,
  input  logic [bank_pkg::HALF_BITS-1:0]      wbuf_fill_data_i,
  output logic                                resp_valid_o,
  input  logic                                resp_ready_i,
  output logic [bank_pkg::CH_BITS-1:0]        resp_ch_id_o,
  output logic [bank_pkg::HALF_BITS-1:0]      resp_data_o,
  output logic                                mem_rd_valid_o,
  input  logic                                mem_rd_ready_i,
  output logic [bank_pkg::LINE_ADDR_BITS-1:0] mem_rd_addr_o,
  input  logic                                mem_rdata_valid_i,
  input  logic [bank_pkg::LINE_BITS-1:0]      mem_rdata_i,
  output logic                                mem_wr_valid_o,
  input  logic                                mem_wr_ready_i,
  output logic [bank_pkg::LINE_ADDR_BITS-1:0] mem_wr_addr_o,
  output logic [bank_pkg::LINE_BITS-1:0]      mem_wr_data_o
);

  logic htu_isu_valid, htu_isu_ready, htu_isu_hit, htu_isu_vdirty, fill_done;
  logic [bank_pkg::CH_BITS-1:0] htu_isu_ch_id;
  bank_pkg::bank_op_e htu_isu_op;
  logic [bank_pkg::SWO_BITS-1:0] htu_isu_swo;
  logic [bank_pkg::WBUF_ID_BITS-1:0] htu_isu_wbuf_id;
  logic htu_rd_valid, htu_rd_ready, htu_ev_valid, htu_ev_ready;
  logic [bank_pkg::LINE_ADDR_BITS-1:0] htu_rd_addr;
  logic [bank_pkg::LINE_ADDR_BITS-1:0] htu_ev_addr;
  logic biu_fill_valid, biu_fill_ready;
  logic [bank_pkg::LINE_BITS-1:0] biu_fill_data;
  logic isu_sc_valid, isu_sc_ready, isu_sc_fill, isu_sc_vdirty;
  logic [bank_pkg::CH_BITS-1:0] isu_sc_ch_id;
  bank_pkg::bank_op_e isu_sc_op;
  logic [bank_pkg::SWO_BITS-1:0] isu_sc_swo;
  logic [bank_pkg::WBUF_ID_BITS-1:0] isu_sc_wbuf_id;
  logic [bank_pkg::LINE_BITS-1:0] isu_sc_fill_data;
  logic sc_ev_valid, sc_ev_ready;
  logic [bank_pkg::LINE_BITS-1:0] sc_ev_data;
  logic wbuf_req_valid, wbuf_req_ready, wbuf_rtn_valid, wbuf_rtn_ready;
  logic [bank_pkg::WBUF_ID_BITS-1:0] wbuf_req_id;
  logic [bank_pkg::HALF_BITS-1:0] wbuf_rtn_data;

  bank_htu htu_i (
    .clk_i(clk_i), .rst_i(rst_i),
    .req_valid_i(req_valid_i), .req_ready_o(req_ready_o), .req_ch_id_i(req_ch_id_i),
    .req_op_i(req_op_i), .req_addr_i(req_addr_i), .req_wbuf_id_i(req_wbuf_id_i),
    .isu_valid_o(htu_isu_valid), .isu_ready_i(htu_isu_ready), .isu_ch_id_o(htu_isu_ch_id),
    .isu_op_o(htu_isu_op), .isu_set_way_offset_o(htu_isu_swo),
    .isu_wbuf_id_o(htu_isu_wbuf_id), .isu_hit_o(htu_isu_hit),
    .isu_victim_dirty_o(htu_isu_vdirty), .fill_done_i(fill_done),
    .rd_valid_o(htu_rd_valid), .rd_ready_i(htu_rd_ready), .rd_addr_o(htu_rd_addr),
    .ev_valid_o(htu_ev_valid), .ev_ready_i(htu_ev_ready), .ev_addr_o(htu_ev_addr)
  );

  bank_isu isu_i (
    .clk_i(clk_i), .rst_i(rst_i),
    .htu_valid_i(htu_isu_valid), .htu_ready_o(htu_isu_ready), .htu_ch_id_i(htu_isu_ch_id),
    .htu_op_i(htu_isu_op), .htu_set_way_offset_i(htu_isu_swo),
    .htu_wbuf_id_i(htu_isu_wbuf_id), .htu_hit_i(htu_isu_hit),
    .htu_victim_dirty_i(htu_isu_vdirty),
    .fill_valid_i(biu_fill_valid), .fill_ready_o(biu_fill_ready),
    .fill_data_i(biu_fill_data), .fill_done_o(fill_done),
    .sc_valid_o(isu_sc_valid), .sc_ready_i(isu_sc_ready), .sc_ch_id_o(isu_sc_ch_id),
    .sc_op_o(isu_sc_op), .sc_set_way_offset_o(isu_sc_swo), .sc_wbuf_id_o(isu_sc_wbuf_id),
    .sc_fill_o(isu_sc_fill), .sc_victim_dirty_o(isu_sc_vdirty),
    .sc_fill_data_o(isu_sc_fill_data)
  );

  bank_sram_ctrl sc_i (
    .clk_i(clk_i), .rst_i(rst_i),
    .isu_valid_i(isu_sc_valid), .isu_ready_o(isu_sc_ready), .isu_ch_id_i(isu_sc_ch_id),
    .isu_op_i(isu_sc_op), .isu_set_way_offset_i(isu_sc_swo), .isu_wbuf_id_i(isu_sc_wbuf_id),
    .isu_fill_i(isu_sc_fill), .isu_victim_dirty_i(isu_sc_vdirty),
    .isu_fill_data_i(isu_sc_fill_data),
    .wbuf_req_valid_o(wbuf_req_valid), .wbuf_req_ready_i(wbuf_req_ready),
    .wbuf_req_id_o(wbuf_req_id),
    .wbuf_rtn_valid_i(wbuf_rtn_valid), .wbuf_rtn_ready_o(wbuf_rtn_ready),
    .wbuf_rtn_data_i(wbuf_rtn_data),
    .ev_valid_o(sc_ev_valid), .ev_ready_i(sc_ev_ready), .ev_data_o(sc_ev_data),
    .resp_valid_o(resp_valid_o), .resp_ready_i(resp_ready_i),
    .resp_ch_id_o(resp_ch_id_o), .resp_data_o(resp_data_o)
  );

  bank_wbuffer wbuf_i (
    .clk_i(clk_i), .rst_i(rst_i),
    .fill_valid_i(wbuf_fill_valid_i), .fill_id_i(wbuf_fill_id_i),
    .fill_data_i(wbuf_fill_data_i),
    .req_valid_i(wbuf_req_valid), .req_ready_o(wbuf_req_ready), .req_id_i(wbuf_req_id),
    .rtn_valid_o(wbuf_rtn_valid), .rtn_ready_i(wbuf_rtn_ready), .rtn_data_o(wbuf_rtn_data)
  );

  bank_biu biu_i (
    .clk_i(clk_i), .rst_i(rst_i),
    .rd_valid_i(htu_rd_valid), .rd_ready_o(htu_rd_ready), .rd_addr_i(htu_rd_addr),
    .ev_addr_valid_i(htu_ev_valid), .ev_addr_ready_o(htu_ev_ready), .ev_addr_i(htu_ev_addr),
    .ev_data_valid_i(sc_ev_valid), .ev_data_ready_o(sc_ev_ready), .ev_data_i(sc_ev_data),
    .fill_valid_o(biu_fill_valid), .fill_ready_i(biu_fill_ready),
    .fill_data_o(biu_fill_data),
    .mem_rd_valid_o(mem_rd_valid_o), .mem_rd_ready_i(mem_rd_ready_i),
    .mem_rd_addr_o(mem_rd_addr_o),
    .mem_rdata_valid_i(mem_rdata_valid_i), .mem_rdata_i(mem_rdata_i),
    .mem_wr_valid_o(mem_wr_valid_o), .mem_wr_ready_i(mem_wr_ready_i),
    .mem_wr_addr_o(mem_wr_addr_o), .mem_wr_data_o(mem_wr_data_o)
  );

endmodule

// File: logic/bank_biu.sv
module bank_biu (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic                                rd_valid_i,
  output logic                                rd_ready_o,
  input  logic [bank_pkg::LINE_ADDR_BITS-1:0] rd_addr_i,
  input  logic                                ev_addr_valid_i,
  output logic                                ev_addr_ready_o,
  input  logic [bank_pkg::LINE_ADDR_BITS-1:0] ev_addr_i,
  input  logic                                ev_data_valid_i,
  output logic                                ev_data_ready_o,
  input  logic [bank_pkg::LINE_BITS-1:0]      ev_data_i,
  output logic                                fill_valid_o,
  input  logic                                fill_ready_i,
  output logic [bank_pkg::LINE_BITS-1:0]      fill_data_o,
  output logic                                mem_rd_valid_o,
  input  logic                                mem_rd_ready_i,
  output logic [bank_pkg::LINE_ADDR_BITS-1:0] mem_rd_addr_o,
  input  logic                                mem_rdata_valid_i,
  input  logic [bank_pkg::LINE_BITS-1:0]      mem_rdata_i,
  output logic                                mem_wr_valid_o,
  input  logic                                mem_wr_ready_i,
  output logic [bank_pkg::LINE_ADDR_BITS-1:0] mem_wr_addr_o,
  output logic [bank_pkg::LINE_BITS-1:0]      mem_wr_data_o
);

  logic [bank_pkg::LINE_ADDR_BITS-1:0] ev_addr_q;
  logic ev_pend_q;
  logic ev_rd_q;
  logic rd_block;
  logic ev_take;

  // A later read must not pass the write back of an older victim.
  assign rd_block        = mem_wr_valid_o || (ev_pend_q && ev_rd_q);
  assign mem_rd_valid_o  = rd_valid_i && !rd_block;
  assign mem_rd_addr_o   = rd_addr_i;
  assign rd_ready_o      = mem_rd_ready_i && !rd_block;
  assign ev_addr_ready_o = !ev_pend_q;
  assign ev_data_ready_o = ev_pend_q && !mem_wr_valid_o;
  assign ev_take         = ev_data_valid_i && ev_data_ready_o;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      ev_pend_q      <= 1'b0;
      ev_rd_q        <= 1'b0;
      fill_valid_o   <= 1'b0;
      mem_wr_valid_o <= 1'b0;
    end else begin
      if (fill_ready_i) fill_valid_o <= 1'b0;
      if (mem_rdata_valid_i) fill_valid_o <= 1'b1;
      if (mem_wr_ready_i) mem_wr_valid_o <= 1'b0;
      if (ev_addr_valid_i && ev_addr_ready_o) ev_pend_q <= 1'b1;
      if (rd_valid_i && rd_ready_o && ev_pend_q) ev_rd_q <= 1'b1;  // Own miss read sent.
      if (ev_take) begin
        mem_wr_valid_o <= 1'b1;
        ev_pend_q      <= 1'b0;
        ev_rd_q        <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_rdata_valid_i) fill_data_o <= mem_rdata_i;
    if (ev_addr_valid_i && ev_addr_ready_o) ev_addr_q <= ev_addr_i;
    if (ev_take) begin
      mem_wr_addr_o <= ev_addr_q;
      mem_wr_data_o <= ev_data_i;
    end
  end

endmodule

// File: logic/bank_wbuffer.sv
module bank_wbuffer (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              fill_valid_i,
  input  logic [bank_pkg::WBUF_ID_BITS-1:0] fill_id_i,
  input  logic [bank_pkg::HALF_BITS-1:0]    fill_data_i,
  input  logic                              req_valid_i,
  output logic                              req_ready_o,
  input  logic [bank_pkg::WBUF_ID_BITS-1:0] req_id_i,
  output logic                              rtn_valid_o,
  input  logic                              rtn_ready_i,
  output logic [bank_pkg::HALF_BITS-1:0]    rtn_data_o
);

  logic [bank_pkg::HALF_BITS-1:0] mem_q [bank_pkg::WBUF_DEPTH];

  assign req_ready_o = !rtn_valid_o || rtn_ready_i;

  always_ff @(posedge clk_i) begin
    if (fill_valid_i) mem_q[fill_id_i] <= fill_data_i;
    if (req_valid_i && req_ready_o) rtn_data_o <= mem_q[req_id_i];
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rtn_valid_o <= 1'b0;
    end else if (req_ready_o) begin
      rtn_valid_o <= req_valid_i;  // Data follows one cycle later.
    end
  end

endmodule

// File: logic/bank_sram_ctrl.sv
module bank_sram_ctrl (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              isu_valid_i,
  output logic                              isu_ready_o,
  input  logic [bank_pkg::CH_BITS-1:0]      isu_ch_id_i,
  input  bank_pkg::bank_op_e                isu_op_i,
  input  logic [bank_pkg::SWO_BITS-1:0]     isu_set_way_offset_i,
  input  logic [bank_pkg::WBUF_ID_BITS-1:0] isu_wbuf_id_i,
  input  logic                              isu_fill_i,
  input  logic                              isu_victim_dirty_i,
  input  logic [bank_pkg::LINE_BITS-1:0]    isu_fill_data_i,
  output logic                              wbuf_req_valid_o,
  input  logic                              wbuf_req_ready_i,
  output logic [bank_pkg::WBUF_ID_BITS-1:0] wbuf_req_id_o,
  input  logic                              wbuf_rtn_valid_i,
  output logic                              wbuf_rtn_ready_o,
  input  logic [bank_pkg::HALF_BITS-1:0]    wbuf_rtn_data_i,
  output logic                              ev_valid_o,
  input  logic                              ev_ready_i,
  output logic [bank_pkg::LINE_BITS-1:0]    ev_data_o,
  output logic                              resp_valid_o,
  input  logic                              resp_ready_i,
  output logic [bank_pkg::CH_BITS-1:0]      resp_ch_id_o,
  output logic [bank_pkg::HALF_BITS-1:0]    resp_data_o
);

  bank_pkg::sc_state_e state_q;
  bank_pkg::bank_op_e op_q;
  logic [bank_pkg::LINE_BITS-1:0] data_q [bank_pkg::BANK_LINES];
  logic [bank_pkg::CH_BITS-1:0] ch_q;
  logic [bank_pkg::SWO_BITS-1:0] swo_q;
  logic [bank_pkg::LINE_BITS-1:0] fill_q;
  logic [bank_pkg::LINE_BITS-1:0] isu_line;
  logic [bank_pkg::LINE_BITS-1:0] cur_line;
  logic resp_free;
  logic accept;
  logic hit_read;
  logic rtn_take;
  logic acc_done;
  logic is_write;

  assign isu_line  = data_q[isu_set_way_offset_i[bank_pkg::SWO_BITS-1:1]];
  assign cur_line  = data_q[swo_q[bank_pkg::SWO_BITS-1:1]];
  assign is_write  = (op_q == bank_pkg::BANK_OP_WRITE);
  assign resp_free = !resp_valid_o || resp_ready_i;
  assign isu_ready_o = (state_q == bank_pkg::SC_IDLE) && resp_free;
  assign accept    = isu_valid_i && isu_ready_o;
  assign hit_read  = accept && !isu_fill_i && (isu_op_i == bank_pkg::BANK_OP_READ);
  assign wbuf_rtn_ready_o = (state_q == bank_pkg::SC_ACCESS) && is_write && resp_free;
  assign rtn_take  = wbuf_rtn_valid_i && wbuf_rtn_ready_o;
  assign acc_done  = (state_q == bank_pkg::SC_ACCESS) && (is_write ? rtn_take : resp_free);

  always_ff @(posedge clk_i) begin
    if (state_q == bank_pkg::SC_FILL) begin
      data_q[swo_q[bank_pkg::SWO_BITS-1:1]] <= fill_q;
    end else if (rtn_take) begin
      data_q[swo_q[bank_pkg::SWO_BITS-1:1]][swo_q[0]*bank_pkg::HALF_BITS +: bank_pkg::HALF_BITS]
        <= wbuf_rtn_data_i;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q          <= bank_pkg::SC_IDLE;
      ev_valid_o       <= 1'b0;
      wbuf_req_valid_o <= 1'b0;
      resp_valid_o     <= 1'b0;
    end else begin
      if (resp_ready_i) resp_valid_o <= 1'b0;
      if (wbuf_req_ready_i) wbuf_req_valid_o <= 1'b0;
      case (state_q)
        bank_pkg::SC_IDLE: begin
          if (hit_read) begin
            resp_valid_o <= 1'b1;  // Read hit answers at once.
          end else if (accept && isu_fill_i) begin
            ev_valid_o <= isu_victim_dirty_i;
            state_q    <= isu_victim_dirty_i ? bank_pkg::SC_EVICT : bank_pkg::SC_FILL;
          end else if (accept) begin
            wbuf_req_valid_o <= 1'b1;
            state_q          <= bank_pkg::SC_ACCESS;
          end
        end
        bank_pkg::SC_EVICT: begin
          if (ev_ready_i) begin
            ev_valid_o <= 1'b0;
            state_q    <= bank_pkg::SC_FILL;
          end
        end
        bank_pkg::SC_FILL: begin
          wbuf_req_valid_o <= is_write;
          state_q          <= bank_pkg::SC_ACCESS;
        end
        default: begin
          if (acc_done) begin
            resp_valid_o <= 1'b1;
            state_q      <= bank_pkg::SC_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      ch_q          <= isu_ch_id_i;
      op_q          <= isu_op_i;
      swo_q         <= isu_set_way_offset_i;
      wbuf_req_id_o <= isu_wbuf_id_i;
      fill_q        <= isu_fill_data_i;
      ev_data_o     <= isu_line;  // Victim is still intact here.
    end
    if (hit_read) begin
      resp_ch_id_o <= isu_ch_id_i;
      resp_data_o  <= isu_line[isu_set_way_offset_i[0]*bank_pkg::HALF_BITS +: bank_pkg::HALF_BITS];
    end else if (acc_done) begin
      resp_ch_id_o <= ch_q;
      resp_data_o  <= is_write ? wbuf_rtn_data_i
                               : cur_line[swo_q[0]*bank_pkg::HALF_BITS +: bank_pkg::HALF_BITS];
    end
  end

endmodule

// File: logic/bank_isu.sv
module bank_isu (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              htu_valid_i,
  output logic                              htu_ready_o,
  input  logic [bank_pkg::CH_BITS-1:0]      htu_ch_id_i,
  input  bank_pkg::bank_op_e                htu_op_i,
  input  logic [bank_pkg::SWO_BITS-1:0]     htu_set_way_offset_i,
  input  logic [bank_pkg::WBUF_ID_BITS-1:0] htu_wbuf_id_i,
  input  logic                              htu_hit_i,
  input  logic                              htu_victim_dirty_i,
  input  logic                              fill_valid_i,
  output logic                              fill_ready_o,
  input  logic [bank_pkg::LINE_BITS-1:0]    fill_data_i,
  output logic                              fill_done_o,
  output logic                              sc_valid_o,
  input  logic                              sc_ready_i,
  output logic [bank_pkg::CH_BITS-1:0]      sc_ch_id_o,
  output bank_pkg::bank_op_e                sc_op_o,
  output logic [bank_pkg::SWO_BITS-1:0]     sc_set_way_offset_o,
  output logic [bank_pkg::WBUF_ID_BITS-1:0] sc_wbuf_id_o,
  output logic                              sc_fill_o,
  output logic                              sc_victim_dirty_o,
  output logic [bank_pkg::LINE_BITS-1:0]    sc_fill_data_o
);

  logic valid_q;
  logic hit_q;
  logic have_fill_q;
  logic take;

  // A miss waits here for its line.
  assign sc_valid_o   = valid_q && (hit_q || have_fill_q);
  assign take         = sc_valid_o && sc_ready_i;
  assign htu_ready_o  = !valid_q || take;
  assign fill_ready_o = valid_q && !hit_q && !have_fill_q;
  assign fill_done_o  = take && !hit_q;
  assign sc_fill_o    = !hit_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      valid_q     <= 1'b0;
      have_fill_q <= 1'b0;
    end else begin
      if (fill_valid_i && fill_ready_o) have_fill_q <= 1'b1;
      if (htu_ready_o) begin
        valid_q     <= htu_valid_i;
        have_fill_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (htu_valid_i && htu_ready_o) begin
      sc_ch_id_o          <= htu_ch_id_i;
      sc_op_o             <= htu_op_i;
      sc_set_way_offset_o <= htu_set_way_offset_i;
      sc_wbuf_id_o        <= htu_wbuf_id_i;
      sc_victim_dirty_o   <= htu_victim_dirty_i;
      hit_q               <= htu_hit_i;
    end
    if (fill_valid_i && fill_ready_o) sc_fill_data_o <= fill_data_i;
  end

endmodule

// File: logic/bank_htu.sv
module bank_htu (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  input  logic [bank_pkg::CH_BITS-1:0]        req_ch_id_i,
  input  bank_pkg::bank_op_e                  req_op_i,
  input  logic [bank_pkg::ADDR_BITS-1:0]      req_addr_i,
  input  logic [bank_pkg::WBUF_ID_BITS-1:0]   req_wbuf_id_i,
  output logic                                isu_valid_o,
  input  logic                                isu_ready_i,
  output logic [bank_pkg::CH_BITS-1:0]        isu_ch_id_o,
  output bank_pkg::bank_op_e                  isu_op_o,
  output logic [bank_pkg::SWO_BITS-1:0]       isu_set_way_offset_o,
  output logic [bank_pkg::WBUF_ID_BITS-1:0]   isu_wbuf_id_o,
  output logic                                isu_hit_o,
  output logic                                isu_victim_dirty_o,
  input  logic                                fill_done_i,
  output logic                                rd_valid_o,
  input  logic                                rd_ready_i,
  output logic [bank_pkg::LINE_ADDR_BITS-1:0] rd_addr_o,
  output logic                                ev_valid_o,
  input  logic                                ev_ready_i,
  output logic [bank_pkg::LINE_ADDR_BITS-1:0] ev_addr_o
);

  logic [bank_pkg::TAG_BITS-1:0] tag_q [bank_pkg::BANK_SETS][bank_pkg::BANK_WAYS];
  logic [bank_pkg::BANK_SETS-1:0][bank_pkg::BANK_WAYS-1:0] valid_q;
  logic [bank_pkg::BANK_SETS-1:0][bank_pkg::BANK_WAYS-1:0] dirty_q;
  logic [bank_pkg::BANK_SETS-1:0][bank_pkg::WAY_BITS-1:0] rr_q;
  logic [bank_pkg::BANK_SET_BITS-1:0] set;
  logic [bank_pkg::TAG_BITS-1:0] tag;
  logic [bank_pkg::WAY_BITS-1:0] way;
  logic hit;
  logic victim_dirty;
  logic accept;
  logic wait_q;
  logic rd_pend_q;

  assign set = req_addr_i[bank_pkg::BANK_SET_BITS:1];
  assign tag = req_addr_i[bank_pkg::ADDR_BITS-1:bank_pkg::BANK_SET_BITS+1];

  always_comb begin
    hit = 1'b0;
    way = rr_q[set];  // Victim unless a way hits.
    for (int w = 0; w < bank_pkg::BANK_WAYS; w++) begin
      if (valid_q[set][w] && tag_q[set][w] == tag) begin
        hit = 1'b1;
        way = w[bank_pkg::WAY_BITS-1:0];
      end
    end
  end

  assign victim_dirty = !hit && valid_q[set][way] && dirty_q[set][way];
  assign req_ready_o  = !wait_q && (!isu_valid_o || isu_ready_i);
  assign accept       = req_valid_i && req_ready_o;
  // Linefill read goes out only once the eviction address has left.
  assign rd_valid_o   = rd_pend_q && !ev_valid_o;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      valid_q     <= '0;
      dirty_q     <= '0;
      rr_q        <= '0;
      wait_q      <= 1'b0;
      rd_pend_q   <= 1'b0;
      ev_valid_o  <= 1'b0;
      isu_valid_o <= 1'b0;
    end else begin
      if (!isu_valid_o || isu_ready_i) isu_valid_o <= accept;
      if (rd_valid_o && rd_ready_i) rd_pend_q <= 1'b0;
      if (ev_valid_o && ev_ready_i) ev_valid_o <= 1'b0;
      if (fill_done_i) wait_q <= 1'b0;
      if (accept) begin
        dirty_q[set][way] <= (req_op_i == bank_pkg::BANK_OP_WRITE) || (hit && dirty_q[set][way]);
        if (!hit) begin
          valid_q[set][way] <= 1'b1;
          rr_q[set]         <= rr_q[set] + 1'b1;
          wait_q            <= 1'b1;  // Blocks until fill_done.
          rd_pend_q         <= 1'b1;
          ev_valid_o        <= victim_dirty;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      isu_ch_id_o          <= req_ch_id_i;
      isu_op_o             <= req_op_i;
      isu_set_way_offset_o <= {set, way, req_addr_i[0]};
      isu_wbuf_id_o        <= req_wbuf_id_i;
      isu_hit_o            <= hit;
      isu_victim_dirty_o   <= victim_dirty;
    end
    if (accept && !hit) begin
      tag_q[set][way] <= tag;
      rd_addr_o       <= req_addr_i[bank_pkg::ADDR_BITS-1:1];
      ev_addr_o       <= {tag_q[set][way], set};  // Old owner of the line.
    end
  end

endmodule

// File: logic/bank_pkg.sv
package bank_pkg;

  localparam int BANK_SETS      = 4;
  localparam int BANK_SET_BITS  = $clog2(BANK_SETS);
  localparam int BANK_WAYS      = 2;
  localparam int WAY_BITS       = $clog2(BANK_WAYS);
  localparam int BANK_LINES     = BANK_SETS * BANK_WAYS;
  localparam int LINE_BITS      = 256;
  localparam int HALF_BITS      = LINE_BITS / 2;
  localparam int ADDR_BITS      = 28;  // Address in 16-byte units.
  localparam int TAG_BITS       = ADDR_BITS - BANK_SET_BITS - 1;
  localparam int LINE_ADDR_BITS = ADDR_BITS - 1;
  localparam int SWO_BITS       = BANK_SET_BITS + WAY_BITS + 1;  // Packed as {set, way, offset}.
  localparam int CH_BITS        = 2;
  localparam int WBUF_ID_BITS   = 3;
  localparam int WBUF_DEPTH     = 1 << WBUF_ID_BITS;

  typedef enum logic {
    BANK_OP_READ  = 1'b0,
    BANK_OP_WRITE = 1'b1
  } bank_op_e;

  typedef enum logic [1:0] {
    SC_IDLE,
    SC_EVICT,
    SC_FILL,
    SC_ACCESS
  } sc_state_e;

endpackage
